// ==== logic/mem_pipe_pkg.sv ====
`default_nettype none

package mem_pipe_pkg;

  ////////////////////////////////////////////////////////////
  // data path widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0]   word_t;
  // rv32i register number
  typedef logic [4:0]        reg_idx_t;
  // one bit per byte lane
  typedef logic [XLEN/8-1:0] byte_en_t;

  ////////////////////////////////////////////////////////////
  // data RAM geometry
  ////////////////////////////////////////////////////////////

  localparam int unsigned RAM_WORDS = 256;
  localparam int unsigned RAM_AW    = $clog2(RAM_WORDS);

  // word address, byte address bits 9:2
  typedef logic [RAM_AW-1:0] ram_addr_t;

  ////////////////////////////////////////////////////////////
  // store and load selectors, one-hot
  ////////////////////////////////////////////////////////////

  typedef logic [2:0] store_sel_t;
  localparam store_sel_t ST_NONE = 3'b000;
  localparam store_sel_t ST_B    = 3'b001;
  localparam store_sel_t ST_H    = 3'b010;
  localparam store_sel_t ST_W    = 3'b100;

  typedef logic [4:0] load_sel_t;
  localparam load_sel_t LD_B  = 5'b00001;
  localparam load_sel_t LD_H  = 5'b00010;
  localparam load_sel_t LD_W  = 5'b00100;
  localparam load_sel_t LD_BU = 5'b01000;
  localparam load_sel_t LD_HU = 5'b10000;

endpackage

`default_nettype wire

// ==== logic/mem_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// memory stage to data RAM
interface mem_port_if;
  import mem_pipe_pkg::*;

  // word address of the access
  ram_addr_t addr;
  // store data, already lane aligned
  word_t     wdata;
  // lanes written when we is high
  byte_en_t  byte_en;
  logic      we;
  // registered read word, one cycle after addr
  word_t     rdata;

  // memory stage side
  modport stage (
    output addr,
    output wdata,
    output byte_en,
    output we,
    input  rdata
  );

  // RAM side
  modport ram (
    input  addr,
    input  wdata,
    input  byte_en,
    input  we,
    output rdata
  );

endinterface

`default_nettype wire

// ==== logic/mem_wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// MEM/WB register contents and write-back result
interface mem_wb_if;
  import mem_pipe_pkg::*;

  logic     valid;
  logic     regwrite;
  logic     memread;
  reg_idx_t rd;
  word_t    alures;
  // aligned, extended load data
  word_t    memres;
  // MEM/WB is frozen this cycle
  logic     hold;
  // selected result, also the forwarding source
  word_t    wb_res;

  modport stage (
    output valid, regwrite, memread, rd, alures, memres, hold,
    input  wb_res
  );

  modport wb (
    input  valid, regwrite, memread, rd, alures, memres, hold,
    output wb_res
  );

endinterface

`default_nettype wire

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic                     bus,
  input  logic                     arst_n,
  input  logic                     stall,
  input  logic                     ex_valid,
  input  mem_pipe_pkg::word_t      ex_alures,
  input  mem_pipe_pkg::reg_idx_t   ex_rs2,
  input  mem_pipe_pkg::word_t      ex_rs2_data,
  input  mem_pipe_pkg::reg_idx_t   ex_rd,
  input  logic                     ex_regwrite,
  input  logic                     ex_memread,
  input  logic                     ex_memwrite,
  input  mem_pipe_pkg::store_sel_t ex_store_sel,
  input  mem_pipe_pkg::load_sel_t  ex_load_sel,
  mem_port_if.stage                mem,
  mem_wb_if.stage                  mwb
);
  import mem_pipe_pkg::*;

  logic      accept;
  logic      re;
  logic      fwd;
  logic [1:0] off;
  logic [7:0] hw_en;
  word_t     st_data;
  word_t     ld_word;
  load_sel_t load_sel_q;
  logic [1:0] off_q;

  // rotate by whole bytes
  function automatic word_t rotl_bytes(word_t w, logic [1:0] k);
    logic [2*XLEN-1:0] dbl;
    dbl = {w, w} << {k, 3'b000};
    return dbl[2*XLEN-1:XLEN];
  endfunction

  function automatic word_t rotr_bytes(word_t w, logic [1:0] k);
    logic [2*XLEN-1:0] dbl;
    dbl = {w, w} >> {k, 3'b000};
    return dbl[XLEN-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // store side
  ////////////////////////////////////////////////////////////

  // strobes under stall are dropped
  assign accept = ex_valid && !stall;
  assign re     = accept && ex_memread;
  assign off    = ex_alures[1:0];

  // forward only on register number match, never from x0
  assign fwd = ex_memwrite && mwb.valid && mwb.regwrite &&
               (mwb.rd == ex_rs2) && (mwb.rd != '0);
  assign st_data = fwd ? mwb.wb_res : ex_rs2_data;

  // halfword pair, wraps lane 3 -> lane 0
  assign hw_en = 8'b0011_0011 << off;

  always_comb begin
    mem.byte_en = '0;
    mem.wdata   = st_data;
    case (ex_store_sel)
      ST_B: begin
        mem.byte_en = 4'b0001 << off;
        // byte copied to every lane
        mem.wdata   = {4{st_data[7:0]}};
      end
      ST_H: begin
        mem.byte_en = hw_en[7:4];
        mem.wdata   = rotl_bytes(st_data, off);
      end
      ST_W: mem.byte_en = '1;
      ST_NONE: mem.byte_en = '0;
      default: mem.byte_en = '0;
    endcase
  end

  assign mem.we = accept && ex_memwrite;
  // held load keeps its word on the read port
  assign mem.addr = stall ? mwb.alures[RAM_AW+1:2] : ex_alures[RAM_AW+1:2];

  ////////////////////////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      mwb.valid    <= 1'b0;
      mwb.regwrite <= 1'b0;
      mwb.memread  <= 1'b0;
      load_sel_q   <= '0;
    end else if (!stall) begin
      // empty slot when nothing accepted
      mwb.valid    <= accept;
      mwb.regwrite <= accept && ex_regwrite;
      mwb.memread  <= re;
      load_sel_q   <= ex_load_sel;
    end
  end

  always_ff @(posedge bus) begin
    if (!stall) begin
      mwb.rd     <= ex_rd;
      mwb.alures <= ex_alures;
      off_q      <= off;
    end
  end

  assign mwb.hold = stall;

  ////////////////////////////////////////////////////////////
  // load side
  ////////////////////////////////////////////////////////////

  // addressed byte down to lane 0
  assign ld_word = rotr_bytes(mem.rdata, off_q);

  always_comb begin
    case (load_sel_q)
      LD_B:    mwb.memres = {{24{ld_word[7]}}, ld_word[7:0]};
      LD_H:    mwb.memres = {{16{ld_word[15]}}, ld_word[15:0]};
      LD_W:    mwb.memres = ld_word;
      LD_BU:   mwb.memres = {24'h0, ld_word[7:0]};
      LD_HU:   mwb.memres = {16'h0, ld_word[15:0]};
      // not one-hot
      default: mwb.memres = '0;
    endcase
  end

  // EX hands over one store kind at most
  a_store_sel: assert property (@(posedge bus) disable iff (!arst_n)
    ex_valid |-> $onehot0(ex_store_sel))
    else $error("store selector not one-hot");

  a_we_re: assert property (@(posedge bus) disable iff (!arst_n)
    !(mem.we && re))
    else $error("load and store in the same item");

endmodule

`default_nettype wire

// ==== logic/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input logic     bus,
  mem_port_if.ram mem
);
  import mem_pipe_pkg::*;

  // word organized, all zero at start
  word_t ram [RAM_WORDS] = '{default: '0};

  ////////////////////////////////////////////////////////////
  // write lanes, then registered read
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (mem.we) begin
      for (int lane = 0; lane < XLEN/8; lane++) begin
        // only enabled lanes change
        if (mem.byte_en[lane]) begin
          ram[mem.addr][8*lane +: 8] <= mem.wdata[8*lane +: 8];
        end
      end
    end
    // whole word every edge
    mem.rdata <= ram[mem.addr];
  end

  // a write must touch at least one lane
  a_we_lanes: assert property (@(posedge bus)
    mem.we |-> (mem.byte_en != '0))
    else $error("RAM write with no byte lane enabled");

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                   bus,
  input  logic                   arst_n,
  input  logic                   we,
  input  mem_pipe_pkg::reg_idx_t waddr,
  input  mem_pipe_pkg::word_t    wdata,
  input  mem_pipe_pkg::reg_idx_t raddr,
  output mem_pipe_pkg::word_t    rdata
);
  import mem_pipe_pkg::*;

  // one entry per register number
  word_t regs [2**$bits(reg_idx_t)];

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      regs <= '{default: '0};
    end else if (we && (waddr != '0)) begin
      // x0 never written
      regs[waddr] <= wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // read port, combinational
  ////////////////////////////////////////////////////////////

  // x0 reads zero
  assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

`default_nettype wire

// ==== logic/wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
  input  logic                   bus,
  input  logic                   arst_n,
  mem_wb_if.wb                   mwb,
  output logic                   rf_we,
  output mem_pipe_pkg::reg_idx_t rf_waddr,
  output mem_pipe_pkg::word_t    rf_wdata
);

  // item in MEM/WB already written
  logic retired;

  // load data or ALU result
  assign mwb.wb_res = mwb.memread ? mwb.memres : mwb.alures;

  assign rf_wdata = mwb.wb_res;
  assign rf_waddr = mwb.rd;
  assign rf_we    = mwb.valid && mwb.regwrite && !retired;

  // set while the item is held and cleared when a new one loads
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      retired <= 1'b0;
    end else begin
      retired <= mwb.hold && (retired || rf_we);
    end
  end

  // a stalled item is written once
  a_write_once: assert property (@(posedge bus) disable iff (!arst_n)
    (rf_we && mwb.hold) |=> !rf_we)
    else $error("held item rewrote the register file");

endmodule

`default_nettype wire

// ==== logic/mem_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_top (
  input  logic                     bus,
  input  logic                     arst_n,
  input  logic                     stall,
  // EX/MEM register
  input  logic                     ex_valid,
  input  mem_pipe_pkg::word_t      ex_alures,
  input  mem_pipe_pkg::reg_idx_t   ex_rs2,
  input  mem_pipe_pkg::word_t      ex_rs2_data,
  input  mem_pipe_pkg::reg_idx_t   ex_rd,
  input  logic                     ex_regwrite,
  input  logic                     ex_memread,
  input  logic                     ex_memwrite,
  input  mem_pipe_pkg::store_sel_t ex_store_sel,
  input  mem_pipe_pkg::load_sel_t  ex_load_sel,
  // register file read port
  input  mem_pipe_pkg::reg_idx_t   rf_raddr,
  output mem_pipe_pkg::word_t      rf_rdata,
  // write-back view
  output logic                     wb_valid,
  output logic                     wb_we,
  output mem_pipe_pkg::reg_idx_t   wb_rd,
  output mem_pipe_pkg::word_t      wb_data
);

  ////////////////////////////////////////////////////////////
  // internal buses
  ////////////////////////////////////////////////////////////

  mem_port_if mem_port_i ();
  mem_wb_if   mwb_i ();

  assign wb_valid = mwb_i.valid;

  ////////////////////////////////////////////////////////////
  // stages
  ////////////////////////////////////////////////////////////

  mem_stage mem_stage_i (
    .bus          (bus),
    .arst_n       (arst_n),
    .stall        (stall),
    .ex_valid     (ex_valid),
    .ex_alures    (ex_alures),
    .ex_rs2       (ex_rs2),
    .ex_rs2_data  (ex_rs2_data),
    .ex_rd        (ex_rd),
    .ex_regwrite  (ex_regwrite),
    .ex_memread   (ex_memread),
    .ex_memwrite  (ex_memwrite),
    .ex_store_sel (ex_store_sel),
    .ex_load_sel  (ex_load_sel),
    .mem          (mem_port_i.stage),
    .mwb          (mwb_i.stage)
  );

  data_ram data_ram_i (
    .bus (bus),
    .mem (mem_port_i.ram)
  );

  // register file write port is the write-back view
  wb_stage wb_stage_i (
    .bus      (bus),
    .arst_n   (arst_n),
    .mwb      (mwb_i.wb),
    .rf_we    (wb_we),
    .rf_waddr (wb_rd),
    .rf_wdata (wb_data)
  );

  reg_file reg_file_i (
    .bus    (bus),
    .arst_n (arst_n),
    .we     (wb_we),
    .waddr  (wb_rd),
    .wdata  (wb_data),
    .raddr  (rf_raddr),
    .rdata  (rf_rdata)
  );

endmodule

`default_nettype wire

// ==== tb/mem_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_tb;
  import mem_pipe_pkg::*;

  localparam int N_RAND    = 800;
  // 3 setup items, 3 x 4 x 6 lane items, 5 stall items
  localparam int DIR_ITEMS = 80;
  localparam int DRAIN     = 3;
  localparam int N_ITEMS   = DIR_ITEMS + N_RAND + DRAIN;

  logic       bus;
  logic       arst_n;
  logic       stall;
  logic       ex_valid;
  word_t      ex_alures;
  reg_idx_t   ex_rs2;
  word_t      ex_rs2_data;
  reg_idx_t   ex_rd;
  logic       ex_regwrite;
  logic       ex_memread;
  logic       ex_memwrite;
  store_sel_t ex_store_sel;
  load_sel_t  ex_load_sel;
  reg_idx_t   rf_raddr;
  word_t      rf_rdata;
  logic       wb_valid;
  logic       wb_we;
  reg_idx_t   wb_rd;
  word_t      wb_data;

  // next item for drive_inputs
  logic       n_valid, n_stall, n_regwrite, n_memread, n_memwrite;
  word_t      n_alures, n_rs2_data;
  reg_idx_t   n_rs2, n_rd;
  store_sel_t n_store_sel;
  load_sel_t  n_load_sel;

  // model of the MEM/WB slot
  // s_fresh marks the first cycle of an item in MEM/WB
  logic       s_valid, s_regwrite, s_fresh;
  reg_idx_t   s_rd;
  word_t      s_res;

  word_t       model_ram [RAM_WORDS];
  word_t       model_rf [32];
  logic [31:0] lfsr = 32'h0000_888e;
  int          checks = 0;
  int          errors = 0;

  mem_pipe_top mem_pipe_top_i (
    .bus (bus), .arst_n (arst_n), .stall (stall),
    .ex_valid (ex_valid), .ex_alures (ex_alures), .ex_rs2 (ex_rs2),
    .ex_rs2_data (ex_rs2_data), .ex_rd (ex_rd), .ex_regwrite (ex_regwrite),
    .ex_memread (ex_memread), .ex_memwrite (ex_memwrite),
    .ex_store_sel (ex_store_sel), .ex_load_sel (ex_load_sel),
    .rf_raddr (rf_raddr), .rf_rdata (rf_rdata),
    .wb_valid (wb_valid), .wb_we (wb_we), .wb_rd (wb_rd), .wb_data (wb_data)
  );

  initial begin
    bus = 1'b0;
    forever #10 bus = ~bus;
  end

  // run time bound from the item count
  initial begin
    #((N_ITEMS + 100) * 20);
    $display("timeout, run did not end within %0d cycles", N_ITEMS + 100);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  // stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic load_sel_t load_kind(input int i);
    case (i)
      0:       return LD_B;
      1:       return LD_H;
      2:       return LD_W;
      3:       return LD_BU;
      default: return LD_HU;
    endcase
  endfunction

  // addressed byte to lane 0 then cut and extend
  function automatic word_t load_value(input word_t w, input logic [1:0] k, input load_sel_t sel);
    word_t r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = w[8*((i + int'(k)) % 4) +: 8];
    end
    case (sel)
      LD_B:    return {{24{r[7]}}, r[7:0]};
      LD_H:    return {{16{r[15]}}, r[15:0]};
      LD_W:    return r;
      LD_BU:   return {24'h0, r[7:0]};
      LD_HU:   return {16'h0, r[15:0]};
      default: return '0;
    endcase
  endfunction

  function automatic void store_model(input store_sel_t sel, input ram_addr_t w,
                                      input logic [1:0] k, input word_t d);
    logic [1:0] k1;
    // upper half goes to the next lane and wraps 3 -> 0
    k1 = k + 2'd1;
    case (sel)
      ST_B: model_ram[w][8*k +: 8] = d[7:0];
      ST_H: begin
        model_ram[w][8*k +: 8]  = d[7:0];
        model_ram[w][8*k1 +: 8] = d[15:8];
      end
      ST_W:    model_ram[w] = d;
      default: ;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // item builders
  ////////////////////////////////////////////////////////////

  task automatic base_item();
    n_valid     = 1'b1;
    n_regwrite  = 1'b0;
    n_memread   = 1'b0;
    n_memwrite  = 1'b0;
    n_store_sel = ST_NONE;
    n_load_sel  = '0;
    n_alures    = '0;
    n_rs2       = '0;
    n_rs2_data  = '0;
    n_rd        = '0;
  endtask

  task automatic alu_item(input reg_idx_t rd, input word_t val);
    base_item();
    n_regwrite = 1'b1;
    n_rd       = rd;
    n_alures   = val;
  endtask

  task automatic store_item(input store_sel_t sel, input word_t addr, input reg_idx_t rs2,
                            input word_t data);
    base_item();
    n_memwrite  = 1'b1;
    n_store_sel = sel;
    n_alures    = addr;
    n_rs2       = rs2;
    n_rs2_data  = data;
  endtask

  task automatic load_item(input load_sel_t sel, input word_t addr, input reg_idx_t rd);
    base_item();
    n_regwrite = 1'b1;
    n_memread  = 1'b1;
    n_load_sel = sel;
    n_alures   = addr;
    n_rd       = rd;
  endtask

  task automatic random_item();
    logic [31:0] kind;
    logic [31:0] wrd;
    logic [31:0] lane;
    logic [31:0] v;
    kind = rand_bits(3);
    wrd  = rand_bits(4);
    lane = rand_bits(2);
    v    = rand_bits(5);
    if (kind[2:0] < 3'd2) begin
      alu_item(v[4:0], rand_bits(32));
    end else if (kind[2:0] < 3'd5) begin
      store_item(ST_W, {26'h0, wrd[3:0], lane[1:0]}, v[4:0], rand_bits(32));
      v = rand_bits(2);
      if (v[1:0] == 2'd0) n_store_sel = ST_B;
      else if (v[1:0] == 2'd1) n_store_sel = ST_H;
      // often hit the register held in MEM/WB
      v = rand_bits(1);
      if (v[0]) n_rs2 = s_rd;
    end else begin
      load_item(LD_W, {26'h0, wrd[3:0], lane[1:0]}, v[4:0]);
      v = rand_bits(3);
      n_load_sel = load_kind(int'(v[2:0]) % 5);
    end
  endtask

  task automatic drive_inputs();
    stall        = n_stall;
    ex_valid     = n_valid;
    ex_alures    = n_alures;
    ex_rs2       = n_rs2;
    ex_rs2_data  = n_rs2_data;
    ex_rd        = n_rd;
    ex_regwrite  = n_regwrite;
    ex_memread   = n_memread;
    ex_memwrite  = n_memwrite;
    ex_store_sel = n_store_sel;
    ex_load_sel  = n_load_sel;
  endtask

  ////////////////////////////////////////////////////////////
  // one cycle of slot check, drive and model update
  ////////////////////////////////////////////////////////////

  task automatic step();
    logic      want_we;
    logic      fwd;
    word_t     sdata;
    ram_addr_t w;
    logic [1:0] k;
    @(posedge bus);
    #2;
    want_we = s_valid && s_regwrite && s_fresh;
    compare("wb_valid", {31'h0, wb_valid}, {31'h0, s_valid});
    compare("wb_we", {31'h0, wb_we}, {31'h0, want_we});
    if (s_valid) begin
      compare("wb_rd", {27'h0, wb_rd}, {27'h0, s_rd});
      compare("wb_data", wb_data, s_res);
    end
    // register file takes it at the coming edge
    if (want_we && (s_rd != 5'd0)) model_rf[s_rd] = s_res;
    drive_inputs();
    fwd   = s_valid && s_regwrite && (s_rd == n_rs2) && (s_rd != 5'd0);
    sdata = fwd ? s_res : n_rs2_data;
    // only a newly loaded item may write the register file
    s_fresh = !n_stall;
    if (!n_stall) begin
      w          = n_alures[RAM_AW+1:2];
      k          = n_alures[1:0];
      s_valid    = n_valid;
      s_regwrite = n_valid && n_regwrite;
      s_rd       = n_rd;
      s_res      = n_alures;
      if (n_valid && n_memread) s_res = load_value(model_ram[w], k, n_load_sel);
      if (n_valid && n_memwrite) store_model(n_store_sel, w, k, sdata);
    end
  endtask

  task automatic sweep_regs();
    for (int r = 0; r < 32; r++) begin
      rf_raddr = 5'(r);
      #1;
      compare($sformatf("rf_rdata[x%0d]", r), rf_rdata, model_rf[r]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          stall_left;
    logic [31:0] v;
    store_sel_t  sel;
    stall_left = 0;
    arst_n     = 1'b0;
    rf_raddr   = '0;
    base_item();
    n_valid = 1'b0;
    n_stall = 1'b0;
    drive_inputs();
    s_valid    = 1'b0;
    s_regwrite = 1'b0;
    s_fresh    = 1'b0;
    s_rd       = '0;
    s_res      = '0;
    for (int i = 0; i < RAM_WORDS; i++) model_ram[i] = '0;
    for (int i = 0; i < 32; i++) model_rf[i] = '0;

    repeat (2) @(posedge bus);
    #2;
    arst_n = 1'b1;
    compare("wb_valid", {31'h0, wb_valid}, 32'h0);
    compare("wb_we", {31'h0, wb_we}, 32'h0);
    sweep_regs();

    // x0 write then a store fed by forwarding
    alu_item(5'd0, 32'hdead_beef);
    step();
    alu_item(5'd5, 32'h1234_5678);
    step();
    store_item(ST_W, 32'h40, 5'd5, 32'hffff_ffff);
    step();

    // every store kind and offset read back by every load kind
    for (int s = 0; s < 3; s++) begin
      sel = (s == 0) ? ST_B : (s == 1) ? ST_H : ST_W;
      for (int k = 0; k < 4; k++) begin
        store_item(sel, 32'(32 + 4*s + k), 5'd0, rand_bits(32));
        step();
        for (int l = 0; l < 5; l++) begin
          load_item(load_kind(l), 32'(32 + 4*s + k), 5'(10 + l));
          step();
        end
      end
    end

    // load held 3 cycles
    // store strobes under stall are dropped
    load_item(LD_W, 32'h40, 5'd7);
    step();
    n_stall = 1'b1;
    store_item(ST_W, 32'h40, 5'd0, 32'h0bad_0bad);
    repeat (3) step();
    n_stall = 1'b0;
    load_item(LD_W, 32'h40, 5'd8);
    step();

    // random traffic with gaps and stalls
    for (int c = 0; c < N_RAND; c++) begin
      if (stall_left == 0) begin
        v = rand_bits(4);
        if (v[3:0] == 4'd0) begin
          v = rand_bits(2);
          stall_left = int'(v[1:0]) + 1;
        end
      end
      n_stall = (stall_left > 0);
      if (stall_left > 0) stall_left--;
      random_item();
      v = rand_bits(3);
      if (v[2:0] == 3'd0) n_valid = 1'b0;
      step();
    end

    // drain MEM/WB into the register file
    n_stall = 1'b0;
    base_item();
    n_valid = 1'b0;
    repeat (DRAIN) step();
    sweep_regs();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mem_pipe.f ====
logic/mem_pipe_pkg.sv
logic/mem_port_if.sv
logic/mem_wb_if.sv
logic/mem_stage.sv
logic/data_ram.sv
logic/reg_file.sv
logic/wb_stage.sv
logic/mem_pipe_top.sv
tb/mem_pipe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mem_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module mem_pipe_tb \
  -Mdir "$BUILD_DIR" -o mem_pipe_sim \
  -f mem_pipe.f \
  || { echo "verilator build failed"; exit 1; }

"./$BUILD_DIR/mem_pipe_sim" 2>&1 | tee "$LOG"

grep -qx "TEST PASS" "$LOG" && echo "mem_pipe: passed" \
  || { echo "mem_pipe: failed"; exit 1; }
